//--- run_sim.sh
#!/bin/sh
# build and run the weight loader testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_weight_loader -f src.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1

//--- source/bank_steer.sv
`timescale 1ns/100ps

module bank_steer #(
    parameter int NUM_BANKS   = 4,
    parameter int CHUNK_WORDS = 6
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 layer_done,
    input  loader_pkg::load_phase_t              phase,
    input  logic                                 bias_full,
    input  logic                                 wr_en,
    input  loader_pkg::len_t                     chunk_len,
    input  logic [NUM_BANKS-1:0]                 bank_full,
    output logic [NUM_BANKS-1:0]                 bank_wr_en,
    output loader_pkg::len_t [NUM_BANKS-1:0]     bank_len,
    output logic                                 bank_advance,
    output logic                                 full_n
);
    import loader_pkg::*;

    localparam int BW = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

    logic [BW-1:0]          ptr;
    logic [BW-1:0]          ptr_nxt;
    len_t [NUM_BANKS-1:0]   len_q;
    logic                   loading;
    logic                   whole_chunk;

    assign loading = (phase == PH_WEIGHT);

    // round robin successor
    assign ptr_nxt = (ptr == BW'(NUM_BANKS - 1)) ? '0 : BW'(ptr + 1'b1);

    //////////////////////////////////////////////////
    // per bank length and write steering

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        logic open;

        assign open = loading && (ptr == BW'(i)) && !bank_full[i];

        // pointed bank sees the fresh length on its first write
        assign bank_len[i]   = open ? chunk_len : len_q[i];
        assign bank_wr_en[i] = open && wr_en;

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                len_q[i] <= '0;
            end else if (open) begin
                len_q[i] <= chunk_len;
            end
        end
    end

    //////////////////////////////////////////////////
    // advance rule and pointer

    assign whole_chunk  = (len_q[ptr] == len_t'(CHUNK_WORDS));
    assign bank_advance = loading && bank_full[ptr] && whole_chunk && !bank_full[ptr_nxt];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (layer_done) begin
            ptr <= '0;
        end else if (bank_advance) begin
            ptr <= ptr_nxt;
        end
    end

    // ready back to the dram reader
    always_comb begin
        case (phase)
            PH_BIAS:   full_n = !bias_full;
            PH_WEIGHT: full_n = !bank_full[ptr];
            default:   full_n = 1'b0;
        endcase
    end

endmodule

//--- source/load_phase_ctrl.sv
`timescale 1ns/100ps

module load_phase_ctrl #(
    parameter int CHUNK_WORDS = 6
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     load_start,
    input  logic                     weight_go,
    input  logic                     layer_done,
    input  logic                     bias_full,
    input  logic                     bank_advance,
    input  loader_pkg::len_t         total_len,
    output loader_pkg::load_phase_t  phase,
    output loader_pkg::len_t         chunk_len
);
    import loader_pkg::*;

    load_phase_t phase_nxt;
    len_t        chunk_cnt;     // chunks handed to banks so far
    logic [31:0] done_words;
    logic [31:0] remain;

    //////////////////////////////////////////////////
    // phase fsm

    always_comb begin
        phase_nxt = phase;
        case (phase)
            PH_IDLE:   if (load_start) phase_nxt = PH_BIAS;
            PH_BIAS:   if (bias_full)  phase_nxt = PH_WAIT;
            PH_WAIT:   if (weight_go)  phase_nxt = PH_WEIGHT;
            PH_WEIGHT: phase_nxt = PH_WEIGHT;
            default:   phase_nxt = PH_IDLE;
        endcase
        if (layer_done) phase_nxt = PH_IDLE;   // from any phase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= PH_IDLE;
        end else begin
            phase <= phase_nxt;
        end
    end

    //////////////////////////////////////////////////
    // chunk count and length

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            chunk_cnt <= '0;
        end else if (layer_done) begin
            chunk_cnt <= '0;
        end else if (bank_advance) begin
            chunk_cnt <= len_t'(chunk_cnt + 16'd1);
        end
    end

    assign done_words = 32'(chunk_cnt) * 32'(CHUNK_WORDS);

    // saturate at zero once the layer is used up
    assign remain = (32'(total_len) > done_words) ? 32'(total_len) - done_words : 32'd0;

    assign chunk_len = (remain < 32'(CHUNK_WORDS)) ? len_t'(remain) : len_t'(CHUNK_WORDS);

endmodule

//--- source/loader_pkg.sv
package loader_pkg;

    //////////////////////////////////////////////////
    // stream and length types

    typedef logic [63:0] word_t;     // one dram stream word
    typedef logic [15:0] len_t;      // length or count in words

    // sizes the bias buffer and every bank
    localparam int MAX_DEPTH = 16;

    //////////////////////////////////////////////////
    // loader phase

    typedef enum logic [1:0] {
        PH_IDLE   = 2'b00,
        PH_BIAS   = 2'b01,
        PH_WAIT   = 2'b10,   // bias loaded and waiting for go
        PH_WEIGHT = 2'b11
    } load_phase_t;

endpackage

//--- source/weight_loader_top.sv
`timescale 1ns/100ps

module weight_loader_top #(
    parameter int NUM_BANKS   = 4,
    parameter int CHUNK_WORDS = 6
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 load_start,
    input  logic                                 weight_go,
    input  logic                                 layer_done,
    input  loader_pkg::len_t                     total_len,
    input  loader_pkg::word_t                    din,
    input  logic                                 wr_en,
    output logic                                 full_n,
    output logic                                 bias_full,
    input  logic                                 bias_rd_en,
    output loader_pkg::word_t                    bias_dout,
    output logic [NUM_BANKS-1:0]                 weight_full,
    input  logic [NUM_BANKS-1:0]                 weight_rd_en,
    output loader_pkg::word_t [NUM_BANKS-1:0]    weight_dout
);
    import loader_pkg::*;

    load_phase_t            phase;
    len_t                   chunk_len;
    logic                   bank_advance;
    logic                   bias_wr_en;
    logic [NUM_BANKS-1:0]   bank_wr_en;
    len_t [NUM_BANKS-1:0]   bank_len;

    //////////////////////////////////////////////////
    // control

    load_phase_ctrl #(
        .CHUNK_WORDS (CHUNK_WORDS)
    ) ctrl_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_start   (load_start),
        .weight_go    (weight_go),
        .layer_done   (layer_done),
        .bias_full    (bias_full),
        .bank_advance (bank_advance),
        .total_len    (total_len),
        .phase        (phase),
        .chunk_len    (chunk_len)
    );

    bank_steer #(
        .NUM_BANKS   (NUM_BANKS),
        .CHUNK_WORDS (CHUNK_WORDS)
    ) steer_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .layer_done   (layer_done),
        .phase        (phase),
        .bias_full    (bias_full),
        .wr_en        (wr_en),
        .chunk_len    (chunk_len),
        .bank_full    (weight_full),
        .bank_wr_en   (bank_wr_en),
        .bank_len     (bank_len),
        .bank_advance (bank_advance),
        .full_n       (full_n)
    );

    //////////////////////////////////////////////////
    // buffers

    assign bias_wr_en = wr_en & (phase == PH_BIAS) & ~bias_full;

    word_buffer bias_buf_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (bias_wr_en),
        .din      (din),
        .fill_len (total_len),   // bias length while in bias phase
        .full     (bias_full),
        .rd_en    (bias_rd_en),
        .dout     (bias_dout)
    );

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_weight
        word_buffer bank_i (
            .clk      (clk),
            .rst_n    (rst_n),
            .wr_en    (bank_wr_en[i]),
            .din      (din),
            .fill_len (bank_len[i]),
            .full     (weight_full[i]),
            .rd_en    (weight_rd_en[i]),
            .dout     (weight_dout[i])
        );
    end

endmodule

//--- source/word_buffer.sv
`timescale 1ns/100ps

module word_buffer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wr_en,
    input  loader_pkg::word_t  din,
    input  loader_pkg::len_t   fill_len,
    output logic               full,
    input  logic               rd_en,
    output loader_pkg::word_t  dout
);
    import loader_pkg::*;

    localparam int AW = $clog2(MAX_DEPTH);

    word_t mem [MAX_DEPTH];

    len_t  wr_cnt;
    len_t  rd_cnt;
    len_t  len_q;      // length of the current fill
    len_t  cur_len;
    logic  wr_last;
    logic  rd_last;
    logic  do_wr;
    logic  do_rd;

    // first write of a fill still sees the new length on the port
    assign cur_len = (wr_cnt == '0) ? fill_len : len_q;

    assign do_wr   = wr_en && !full;
    assign do_rd   = rd_en && full;      // drain only once filled
    assign wr_last = (len_t'(wr_cnt + 16'd1) == cur_len);
    assign rd_last = (len_t'(rd_cnt + 16'd1) == len_q);

    //////////////////////////////////////////////////
    // storage and read data

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_cnt[AW-1:0]] <= din;
        end
        if (do_rd) begin
            dout <= mem[rd_cnt[AW-1:0]];
        end
    end

    //////////////////////////////////////////////////
    // fill and drain control

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_cnt <= '0;
            rd_cnt <= '0;
            len_q  <= '0;
            full   <= 1'b0;
        end else if (do_wr) begin
            if (wr_cnt == '0) len_q <= fill_len;
            if (wr_last) begin
                full <= 1'b1;
            end
            wr_cnt <= len_t'(wr_cnt + 16'd1);
        end else if (do_rd) begin
            if (rd_last) begin
                full   <= 1'b0;     // empty again and ready for the next fill
                wr_cnt <= '0;
                rd_cnt <= '0;
            end else begin
                rd_cnt <= len_t'(rd_cnt + 16'd1);
            end
        end
    end

endmodule

//--- src.f
source/loader_pkg.sv
source/word_buffer.sv
source/load_phase_ctrl.sv
source/bank_steer.sv
source/weight_loader_top.sv
tb/tb_weight_loader.sv

//--- tb/load_stimulus.txt
// columns, all hex: op arg count value
// op 1 start, 2 write, 3 go, 4 read bias, 5 read bank, 6 phase+ready, 7 full, 8 done, 9 end test
// test 1, bias load
1 0 0 4
2 0 4 b1a5000000000000
7 8 0 1
6 2 0 0                      // bias full, ready low
4 0 4 b1a5000000000000
7 8 0 0
9 0 0 0
// test 2, ready held low until go
6 2 0 0
3 0 0 e                      // two whole chunks plus 2
6 3 0 1
9 0 0 0
// test 3, weight chunking
2 0 e c0de000000000000
7 0 0 1
7 1 0 1
7 2 0 1
7 3 0 0
6 3 0 0                      // short chunk, no advance
5 0 6 c0de000000000000
5 1 6 c0de000000000006
5 2 2 c0de00000000000c
9 0 0 0
// test 4, done then a new layer starts at bank 0
8 0 0 0
6 0 0 0
1 0 0 2
2 0 2 b1a5000000000010
3 0 0 1e
2 0 6 d00d000000000000
7 0 0 1
7 1 0 0
9 0 0 0
// test 5, back-pressure on wraparound
2 0 12 d00d000000000006
7 3 0 1
6 3 0 0
5 0 6 d00d000000000000
2 0 6 d00d000000000018      // resumes into bank 0
7 0 0 1
5 0 6 d00d000000000018
5 3 6 d00d000000000012
9 0 0 0
0 0 0 0

//--- tb/tb_weight_loader.sv
`timescale 1ns/100ps

module tb_weight_loader;
    import loader_pkg::*;

    localparam int NB         = 4;
    localparam int CW         = 6;
    localparam int STIM_WORDS = 256;   // four entries per command

    typedef enum logic [7:0] {
        OP_END_STIM    = 8'h00,
        OP_START       = 8'h01,
        OP_WRITE       = 8'h02,
        OP_GO          = 8'h03,
        OP_READ_BIAS   = 8'h04,
        OP_READ_BANK   = 8'h05,
        OP_CHECK_PHASE = 8'h06,
        OP_CHECK_FULL  = 8'h07,
        OP_DONE        = 8'h08,
        OP_END_TEST    = 8'h09
    } stim_op_t;

    logic            clk = 1'b0;
    logic            rst_n;
    logic            load_start;
    logic            weight_go;
    logic            layer_done;
    len_t            total_len;
    word_t           din;
    logic            wr_en;
    logic            full_n;
    logic            bias_full;
    logic            bias_rd_en;
    word_t           bias_dout;
    logic [NB-1:0]   weight_full;
    logic [NB-1:0]   weight_rd_en;
    word_t [NB-1:0]  weight_dout;

    word_t   stim [STIM_WORDS];
    integer  seed;
    int      errors = 0;
    int      checks = 0;
    int      watch_cycles = 0;
    logic    loaded = 1'b0;

    weight_loader_top #(
        .NUM_BANKS   (NB),
        .CHUNK_WORDS (CW)
    ) dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_start   (load_start),
        .weight_go    (weight_go),
        .layer_done   (layer_done),
        .total_len    (total_len),
        .din          (din),
        .wr_en        (wr_en),
        .full_n       (full_n),
        .bias_full    (bias_full),
        .bias_rd_en   (bias_rd_en),
        .bias_dout    (bias_dout),
        .weight_full  (weight_full),
        .weight_rd_en (weight_rd_en),
        .weight_dout  (weight_dout)
    );

    always #50 clk = ~clk;

    //////////////////////////////////////////////////
    // compare tasks

    task automatic next_cycle();
        @(posedge clk);
        #1;   // drive just after the edge
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_phase_ready(input load_phase_t exp_phase, input logic exp_ready);
        load_phase_t got_phase;
        got_phase = dut_i.phase;
        checks++;
        if (got_phase !== exp_phase) begin
            errors++;
            $display("ERROR at %0t: phase %s, expected %s", $time, got_phase.name(),
                     exp_phase.name());
        end
        check_bit(full_n, exp_ready, "full_n");
    endtask

    //////////////////////////////////////////////////
    // stream and consumer drivers

    task automatic write_run(input int count, input word_t base);
        int wait_cnt;
        int gap;
        for (int k = 0; k < count; k++) begin
            din      = base + word_t'(k);
            wr_en    = 1'b1;
            wait_cnt = 0;
            while (!full_n && wait_cnt < 16) begin   // bank advance bubble
                next_cycle();
                wait_cnt++;
            end
            if (!full_n) begin
                errors++;
                $display("write of word %h stalled, the loader never became ready", din);
            end
            next_cycle();
            wr_en = 1'b0;
            gap   = 1 + ($unsigned($random(seed)) % 3);
            repeat (gap) next_cycle();
        end
    endtask

    task automatic read_run(input logic is_bias, input logic [1:0] bank, input int count,
                            input word_t base);
        for (int k = 0; k < count; k++) begin
            if (is_bias) begin
                bias_rd_en = 1'b1;
            end else begin
                weight_rd_en[bank] = 1'b1;
            end
            next_cycle();
            bias_rd_en   = 1'b0;
            weight_rd_en = '0;
            if (is_bias) begin
                check_word(bias_dout, base + word_t'(k), "bias");
            end else begin
                check_word(weight_dout[bank], base + word_t'(k), $sformatf("bank %0d", bank));
            end
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus sequencer

    initial begin
        int         work;
        int         tests;
        int         test_base;
        stim_op_t   op;
        logic [7:0] arg;
        int         count;
        word_t      value;
        seed         = 32'h3927_95e8;
        rst_n        = 1'b0;
        load_start   = 1'b0;
        weight_go    = 1'b0;
        layer_done   = 1'b0;
        total_len    = '0;
        din          = '0;
        wr_en        = 1'b0;
        bias_rd_en   = 1'b0;
        weight_rd_en = '0;
        tests        = 0;
        test_base    = 0;
        $readmemh("tb/load_stimulus.txt", stim);
        work = 0;
        for (int p = 0; p < STIM_WORDS; p += 4) begin
            if (stim[p][7:0] === 8'h00) break;
            work += 1 + int'(stim[p + 2][15:0]);
        end
        watch_cycles = 8 + 20 * work;
        loaded       = 1'b1;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        for (int p = 0; p < STIM_WORDS; p += 4) begin
            op    = stim_op_t'(stim[p][7:0]);
            arg   = stim[p + 1][7:0];
            count = int'(stim[p + 2][15:0]);
            value = stim[p + 3];
            if (op == OP_END_STIM) break;
            case (op)
                OP_START: begin
                    total_len  = value[15:0];   // bias length
                    load_start = 1'b1;
                    next_cycle();
                    load_start = 1'b0;
                end
                OP_WRITE:     write_run(count, value);
                OP_GO: begin
                    total_len = value[15:0];
                    weight_go = 1'b1;
                    next_cycle();
                    weight_go = 1'b0;
                end
                OP_READ_BIAS: read_run(1'b1, 2'd0, count, value);
                OP_READ_BANK: read_run(1'b0, arg[1:0], count, value);
                OP_CHECK_PHASE: check_phase_ready(load_phase_t'(arg[1:0]), value[0]);
                OP_CHECK_FULL: begin
                    if (arg == 8'h08) begin
                        check_bit(bias_full, value[0], "bias_full");
                    end else begin
                        check_bit(weight_full[arg[1:0]], value[0],
                                  $sformatf("bank %0d full", arg[1:0]));
                    end
                end
                OP_DONE: begin
                    layer_done = 1'b1;
                    next_cycle();
                    layer_done = 1'b0;
                end
                OP_END_TEST: begin
                    tests++;
                    $display("test %0d %s, %0d errors", tests,
                             (errors == test_base) ? "passed" : "failed", errors - test_base);
                    test_base = errors;
                end
                default: begin
                    errors++;
                    $display("unknown command %h in the stimulus file", stim[p][7:0]);
                    break;
                end
            endcase
        end
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog budget scales with the stimulus
    initial begin
        wait (loaded);
        repeat (watch_cycles) @(posedge clk);
        $display("timeout: the stimulus did not finish within %0d cycles", watch_cycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule
